//--- dac_sweep_top.f
dac_sweep_pkg.sv
uart_rx.sv
spi_master.sv
sweep_gen.sv
dac_word_rom.sv
dac_sequencer.sv
dac_sweep_top.sv
tb_dac_sweep.sv

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
  --top-module tb_dac_sweep \
  -f dac_sweep_top.f \
  -o sim_tb_dac_sweep

./obj_dir/sim_tb_dac_sweep

//--- tb_dac_sweep.sv
module tb_dac_sweep;
  import dac_sweep_pkg::*;

  localparam int         CLKS_PER_BIT = 8;
  localparam int         CLK_DIV      = 2;
  localparam int         FRAME_GAP    = 4;
  localparam logic [7:0] UP_X         = 8'd25;
  localparam logic [7:0] DOWN_X       = 8'd21;
  localparam logic [7:0] UP_Y         = 8'd43;
  localparam logic [7:0] DOWN_Y       = 8'd41;
  localparam logic [7:0] KEY_START    = 8'h68; // "h"
  localparam logic [7:0] KEY_STOP     = 8'h73; // "s"

  logic clk;
  logic rst;
  logic rx;
  logic sclk;
  logic mosi;
  logic cs_n;
  logic running;

  logic          sclk_q;
  logic          cs_q;
  logic [23:0]   cap_word;
  logic [5:0]    rise_count;
  logic          frame_end;  // one cycle after each cs_n rise
  logic [23:0]   got_word;
  logic [23:0]   exp_word;
  logic [5:0]    got_rises;
  int            fall_count;
  int            done_count;
  int            start_count; // bumped by the stimulus for every "h" sent in idle
  int            model_run;
  logic [2:0]    phase;       // 0 reset, 1 ldac, 2 to 5 channels a to d
  sweep_levels_t ref_lv;
  int            x_wraps;
  int            y_wraps;
  logic          quiet;       // no frame may start while set
  logic [31:0]   seed;

  dac_sweep_top #(
    .CLKS_PER_BIT(CLKS_PER_BIT), .CLK_DIV(CLK_DIV), .FRAME_GAP(FRAME_GAP),
    .UP_X(UP_X), .DOWN_X(DOWN_X), .UP_Y(UP_Y), .DOWN_Y(DOWN_Y)
  ) u_dac_sweep_top (
    .clk, .rst, .rx, .sclk, .mosi, .cs_n, .running
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  task automatic halt_with_error(input string msg);
    $display("%s", msg);
    $display("Errors found");
    $fatal(1, "simulation stopped");
  endtask

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  task automatic draw_random(output logic [31:0] r);
    seed = lcg_next(seed);
    r = seed;
  endtask

  // expected dac word for a frame kind
  function automatic logic [23:0] frame_word(input logic [2:0] ph, input sweep_levels_t lv);
    logic [23:0] w;
    case (ph)
      3'd0:    w = 24'h500001;
      3'd1:    w = 24'h60000f;
      3'd2:    w = {4'h3, 4'h0, lv.a, 8'h00};
      3'd3:    w = {4'h3, 4'h1, lv.b, 8'h00};
      3'd4:    w = {4'h3, 4'h2, lv.c, 8'h00};
      default: w = {4'h3, 4'h3, lv.d, 8'h00};
    endcase
    return w;
  endfunction

  function automatic sweep_levels_t step_levels(input sweep_levels_t lv);
    sweep_levels_t n;
    n = lv;
    if (lv.a > UP_X) begin
      n.a = DOWN_X;
      n.b = UP_X;
      n.c = (lv.c > UP_Y) ? DOWN_Y : lv.c + 8'd1;
      n.d = (lv.c > UP_Y) ? UP_Y : lv.d - 8'd1;
    end else begin
      n.a = lv.a + 8'd1;
      n.b = lv.b - 8'd1;
    end
    return n;
  endfunction

  // spi capture and reference model
  always @(posedge clk) begin
    if (rst) begin
      sclk_q     <= 1'b0;
      cs_q       <= 1'b1;
      cap_word   <= '0;
      rise_count <= '0;
      frame_end  <= 1'b0;
      fall_count <= 0;
      done_count <= 0;
      model_run = 0;
      phase     = 3'd0;
      ref_lv    = '{a: DOWN_X, b: UP_X, c: DOWN_Y, d: UP_Y};
      x_wraps   = 0;
      y_wraps   = 0;
    end else begin
      sclk_q    <= sclk;
      cs_q      <= cs_n;
      frame_end <= 1'b0;
      if (!cs_n && sclk && !sclk_q) begin
        cap_word   <= {cap_word[22:0], mosi};
        rise_count <= rise_count + 6'd1;
      end
      if (cs_q && !cs_n) begin
        rise_count <= '0;
        fall_count <= fall_count + 1;
      end
      if (!cs_q && cs_n) begin
        if (model_run != start_count) begin
          model_run = start_count;
          phase     = 3'd0; // fresh run opens with the reset word
        end
        exp_word   <= frame_word(phase, ref_lv);
        got_word   <= cap_word;
        got_rises  <= rise_count;
        frame_end  <= 1'b1;
        done_count <= done_count + 1;
        if (phase == 3'd2) begin
          if (ref_lv.a > UP_X) x_wraps = x_wraps + 1;
          if (ref_lv.a > UP_X && ref_lv.c > UP_Y) y_wraps = y_wraps + 1;
          ref_lv = step_levels(ref_lv);
        end
        phase = (phase == 3'd5) ? 3'd2 : phase + 3'd1;
      end
    end
  end

  assert property (@(posedge clk) disable iff (rst) frame_end |-> got_word == exp_word)
    else halt_with_error($sformatf("FAIL spi_word expected 0x%06h actual 0x%06h",
                                   $sampled(exp_word), $sampled(got_word)));

  assert property (@(posedge clk) disable iff (rst) frame_end |-> got_rises == 6'd24)
    else halt_with_error($sformatf("FAIL sclk_rises expected 0x18 actual 0x%0h",
                                   $sampled(got_rises)));

  assert property (@(posedge clk) disable iff (rst) cs_n |-> !sclk)
    else halt_with_error("FAIL sclk expected 0x0 actual 0x1 while cs_n is high");

  assert property (@(posedge clk) disable iff (rst) quiet |-> cs_n)
    else halt_with_error("FAIL cs_n expected 0x1 actual 0x0 while stopped");

  assert property (@(posedge clk) disable iff (rst) quiet |-> !running)
    else halt_with_error("FAIL running expected 0x0 actual 0x1 while stopped");

  // frames only open inside a run
  assert property (@(posedge clk) disable iff (rst) $fell(cs_n) |-> running)
    else halt_with_error("FAIL running expected 0x1 actual 0x0 at a cs_n fall");

  // 8n1, lsb first
  task automatic send_byte(input logic [7:0] value, input logic [4:0] idle);
    repeat (idle) @(posedge clk);
    @(posedge clk);
    rx <= 1'b0;
    repeat (CLKS_PER_BIT - 1) @(posedge clk);
    for (int i = 0; i < 8; i++) begin
      @(posedge clk);
      rx <= value[i];
      repeat (CLKS_PER_BIT - 1) @(posedge clk);
    end
    @(posedge clk);
    rx <= 1'b1;
    repeat (CLKS_PER_BIT - 1) @(posedge clk);
  endtask

  task automatic start_run(input int noise);
    logic [31:0] r;
    logic [7:0]  b;
    start_count = start_count + 1;
    draw_random(r);
    send_byte(KEY_START, r[20:16]);
    send_byte(KEY_START, r[12:8]); // ignored, already running
    for (int i = 0; i < noise; i++) begin
      draw_random(r);
      b = r[31:24];
      if (b == KEY_START || b == KEY_STOP) b = 8'h2a;
      send_byte(b, r[20:16]);
    end
  endtask

  task automatic wait_falls(input int target, input int limit);
    int n;
    n = 0;
    while (fall_count < target) begin
      @(posedge clk);
      n = n + 1;
      if (n > limit) halt_with_error("timed out waiting for a chip select fall");
    end
  endtask

  task automatic wait_frames_done(input int target, input int limit);
    int n;
    n = 0;
    while (done_count < target) begin
      @(posedge clk);
      n = n + 1;
      if (n > limit) halt_with_error("timed out waiting for a frame to finish");
    end
  endtask

  task automatic hold_quiet(input int cycles);
    @(posedge clk);
    quiet <= 1'b1;
    repeat (cycles) @(posedge clk);
    quiet <= 1'b0;
  endtask

  initial begin
    rst         = 1'b1;
    rx          = 1'b1;
    quiet       = 1'b0;
    start_count = 0;
    seed        = 32'hf897;
    repeat (10) @(posedge clk);
    rst <= 1'b0;
    hold_quiet(200); // nothing sent yet

    // long run, stop lands inside a C frame
    start_run(3);
    wait_falls(105, 40000);
    send_byte(KEY_STOP, 5'd0);
    wait_frames_done(105, 2000);
    hold_quiet(1500);

    // restart keeps the levels
    start_run(3);
    wait_falls(130, 10000);
    send_byte(KEY_STOP, 5'd0);
    wait_frames_done(130, 2000);
    hold_quiet(500);

    if (x_wraps == 0 || y_wraps == 0) begin
      halt_with_error("the sweep never wrapped both level pairs");
    end else begin
      $display("No errors");
      $finish;
    end
  end

endmodule

//--- dac_sweep_top.sv
module dac_sweep_top #(
  parameter int         CLKS_PER_BIT = 868,
  parameter int         CLK_DIV      = 4,
  parameter int         FRAME_GAP    = 16,
  parameter logic [7:0] UP_X         = 8'd161,
  parameter logic [7:0] DOWN_X       = 8'd21,
  parameter logic [7:0] UP_Y         = 8'd141,
  parameter logic [7:0] DOWN_Y       = 8'd41
) (
  input  logic clk,
  input  logic rst,
  input  logic rx,
  output logic sclk,
  output logic mosi,
  output logic cs_n,
  output logic running
);
  import dac_sweep_pkg::*;

  logic          [7:0] rx_byte;
  logic                rx_valid;
  logic                spi_start;
  logic                spi_done;
  logic                advance;
  word_sel_e           word_sel;
  dac_word_t           tx_word;
  sweep_levels_t       levels;

  uart_rx #(.CLKS_PER_BIT(CLKS_PER_BIT)) u_uart_rx (
    .clk, .rst, .rx, .rx_byte, .rx_valid
  );

  dac_sequencer #(.FRAME_GAP(FRAME_GAP)) u_dac_sequencer (
    .clk, .rst, .rx_byte, .rx_valid, .spi_done,
    .word_sel, .spi_start, .advance, .running
  );

  sweep_gen #(
    .UP_X(UP_X), .DOWN_X(DOWN_X), .UP_Y(UP_Y), .DOWN_Y(DOWN_Y)
  ) u_sweep_gen (
    .clk, .rst, .advance, .levels
  );

  dac_word_rom u_dac_word_rom (.clk, .word_sel, .levels, .tx_word);

  spi_master #(.CLK_DIV(CLK_DIV)) u_spi_master (
    .clk, .rst, .spi_start, .tx_word,
    .sclk, .mosi, .cs_n, .busy(), .spi_done // busy only feeds its own check
  );

endmodule

//--- dac_sequencer.sv
module dac_sequencer #(
  parameter int FRAME_GAP = 16
) (
  input  logic                     clk,
  input  logic                     rst,
  input  logic [7:0]               rx_byte,
  input  logic                     rx_valid,
  input  logic                     spi_done,
  output dac_sweep_pkg::word_sel_e word_sel,
  output logic                     spi_start,
  output logic                     advance,
  output logic                     running
);
  import dac_sweep_pkg::*;

  localparam int GAP_W = $clog2(FRAME_GAP + 2);

  seq_state_e       state_q;
  logic [1:0]       ch_q;    // channel of the frame in flight
  logic [GAP_W-1:0] gap_q;   // nonzero while waiting between frames
  logic             pend_q;  // word_sel just set, start goes out next
  logic             start_cmd;
  logic             stop_cmd;
  logic             launch;
  word_sel_e        ch_sel;

  assign start_cmd = rx_valid && rx_byte == CHAR_START && state_q == ST_IDLE;
  assign stop_cmd  = rx_valid && rx_byte == CHAR_STOP && state_q != ST_IDLE;
  assign launch    = gap_q == GAP_W'(1); // last gap cycle
  assign running   = state_q != ST_IDLE;
  assign advance   = spi_done && state_q == ST_SET_CHANNEL && ch_q == 2'd0;

  always_comb begin
    case (ch_q)
      2'd0:    ch_sel = SEL_CH_A;
      2'd1:    ch_sel = SEL_CH_B;
      2'd2:    ch_sel = SEL_CH_C;
      default: ch_sel = SEL_CH_D;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state_q   <= ST_IDLE;
      ch_q      <= 2'd0;
      gap_q     <= '0;
      pend_q    <= 1'b0;
      spi_start <= 1'b0;
      word_sel  <= SEL_RESET;
    end else begin
      spi_start <= pend_q && !stop_cmd; // start dropped if a stop lands here
      pend_q    <= 1'b0;
      if (stop_cmd) begin
        // frame on the wire finishes by itself
        state_q <= ST_IDLE;
        gap_q   <= '0;
      end else if (state_q == ST_IDLE) begin
        if (start_cmd) begin
          state_q  <= ST_SOFT_RESET;
          word_sel <= SEL_RESET;
          pend_q   <= 1'b1;
        end
      end else begin
        if (gap_q != '0) gap_q <= gap_q - 1'b1;
        if (launch) begin
          word_sel <= (state_q == ST_LDAC_SETUP) ? SEL_LDAC : ch_sel;
          pend_q   <= 1'b1;
        end
        if (spi_done) begin
          gap_q <= GAP_W'(FRAME_GAP + 1);
          case (state_q)
            ST_SOFT_RESET: state_q <= ST_LDAC_SETUP;
            ST_LDAC_SETUP: begin
              state_q <= ST_SET_CHANNEL;
              ch_q    <= 2'd0;
            end
            default: ch_q <= ch_q + 2'd1; // A B C D then A
          endcase
        end
      end
    end
  end

  assert property (@(posedge clk) disable iff (rst) state_q == ST_IDLE |-> !spi_start)
    else $error("spi_start issued while idle");

endmodule

//--- dac_word_rom.sv
module dac_word_rom (
  input  logic                         clk,
  input  dac_sweep_pkg::word_sel_e     word_sel,
  input  dac_sweep_pkg::sweep_levels_t levels,
  output dac_sweep_pkg::dac_word_t     tx_word
);
  import dac_sweep_pkg::*;

  // write and update one channel, level in the upper data byte
  function automatic dac_word_t ch_word(input logic [3:0] addr, input logic [7:0] level);
    dac_word_t w;
    w.cmd  = CMD_WRITE_UPDATE;
    w.addr = addr;
    w.data = {level, 8'h00};
    return w;
  endfunction

  always_ff @(posedge clk) begin
    case (word_sel)
      SEL_RESET: tx_word <= WORD_RESET;
      SEL_LDAC:  tx_word <= WORD_LDAC;
      SEL_CH_A:  tx_word <= ch_word(ADDR_CH_A, levels.a);
      SEL_CH_B:  tx_word <= ch_word(ADDR_CH_B, levels.b);
      SEL_CH_C:  tx_word <= ch_word(ADDR_CH_C, levels.c);
      SEL_CH_D:  tx_word <= ch_word(ADDR_CH_D, levels.d);
      default:   tx_word <= WORD_RESET;
    endcase
  end

endmodule

//--- sweep_gen.sv
module sweep_gen #(
  parameter logic [7:0] UP_X   = 8'd161,
  parameter logic [7:0] DOWN_X = 8'd21,
  parameter logic [7:0] UP_Y   = 8'd141,
  parameter logic [7:0] DOWN_Y = 8'd41
) (
  input  logic                         clk,
  input  logic                         rst,
  input  logic                         advance,
  output dac_sweep_pkg::sweep_levels_t levels
);

  always_ff @(posedge clk) begin
    if (rst) begin
      levels.a <= DOWN_X;
      levels.b <= UP_X;
      levels.c <= DOWN_Y;
      levels.d <= UP_Y;
    end else if (advance) begin
      if (levels.a > UP_X) begin
        // x pair wraps, y pair takes one step
        levels.a <= DOWN_X;
        levels.b <= UP_X;
        if (levels.c > UP_Y) begin
          levels.c <= DOWN_Y;
          levels.d <= UP_Y;
        end else begin
          levels.c <= levels.c + 8'd1;
          levels.d <= levels.d - 8'd1;
        end
      end else begin
        levels.a <= levels.a + 8'd1;
        levels.b <= levels.b - 8'd1;
      end
    end
  end

  // a and c may sit one above their limit until the next wrap
  assert property (@(posedge clk) disable iff (rst)
    levels.a >= DOWN_X && {1'b0, levels.a} <= {1'b0, UP_X} + 9'd1)
    else $error("level a out of range: %0d", levels.a);

  assert property (@(posedge clk) disable iff (rst)
    levels.c >= DOWN_Y && {1'b0, levels.c} <= {1'b0, UP_Y} + 9'd1)
    else $error("level c out of range: %0d", levels.c);

endmodule

//--- spi_master.sv
module spi_master #(
  parameter int CLK_DIV = 4
) (
  input  logic                     clk,
  input  logic                     rst,
  input  logic                     spi_start,
  input  dac_sweep_pkg::dac_word_t tx_word,
  output logic                     sclk,
  output logic                     mosi,
  output logic                     cs_n,
  output logic                     busy,
  output logic                     spi_done
);
  import dac_sweep_pkg::*;

  localparam int WORD_BITS = $bits(dac_word_t);
  localparam int DIV_W     = $clog2(CLK_DIV + 1);
  localparam int HALF_W    = $clog2(2 * WORD_BITS);

  typedef enum logic [1:0] {
    SPI_IDLE,
    SPI_SETUP,
    SPI_SHIFT,
    SPI_HOLD
  } spi_state_e;

  spi_state_e           state_q;
  logic [DIV_W-1:0]     div_q;
  logic [HALF_W-1:0]    half_q;  // sclk half period index in the frame
  logic [WORD_BITS-1:0] shift_q;
  logic                 half_end;

  assign half_end = div_q == DIV_W'(CLK_DIV - 1);
  assign busy     = state_q != SPI_IDLE;
  assign mosi     = shift_q[WORD_BITS-1]; // zeros shifted in, idles low

  always_ff @(posedge clk) begin
    if (rst) begin
      state_q  <= SPI_IDLE;
      div_q    <= '0;
      half_q   <= '0;
      shift_q  <= '0;
      sclk     <= 1'b0;
      cs_n     <= 1'b1;
      spi_done <= 1'b0;
    end else begin
      spi_done <= 1'b0;
      div_q    <= (state_q == SPI_IDLE || half_end) ? '0 : div_q + 1'b1;
      case (state_q)
        SPI_IDLE: begin
          if (spi_start) begin
            shift_q <= tx_word;
            cs_n    <= 1'b0;
            state_q <= SPI_SETUP;
          end
        end
        SPI_SETUP: begin
          if (half_end) begin
            sclk    <= 1'b1; // first rise samples the msb
            half_q  <= '0;
            state_q <= SPI_SHIFT;
          end
        end
        SPI_SHIFT: begin
          if (half_end) begin
            if (half_q == HALF_W'(2 * WORD_BITS - 1)) begin
              state_q <= SPI_HOLD;
            end else begin
              half_q <= half_q + 1'b1;
              sclk   <= ~sclk;
              if (sclk) shift_q <= {shift_q[WORD_BITS-2:0], 1'b0}; // next bit on fall
            end
          end
        end
        default: begin
          if (half_end) begin
            cs_n     <= 1'b1;
            spi_done <= 1'b1;
            state_q  <= SPI_IDLE;
          end
        end
      endcase
    end
  end

  assert property (@(posedge clk) disable iff (rst) cs_n |-> !sclk)
    else $error("sclk high while cs_n is high");

  assert property (@(posedge clk) disable iff (rst) spi_start |-> !busy)
    else $error("spi_start while a frame is in flight");

endmodule

//--- uart_rx.sv
module uart_rx #(
  parameter int CLKS_PER_BIT = 868
) (
  input  logic       clk,
  input  logic       rst,
  input  logic       rx,
  output logic [7:0] rx_byte,
  output logic       rx_valid
);

  localparam int CNT_W = $clog2(CLKS_PER_BIT + 1);

  typedef enum logic [1:0] {
    RX_IDLE,
    RX_START,
    RX_DATA,
    RX_STOP
  } rx_state_e;

  rx_state_e        state_q;
  logic [1:0]       sync_q;  // two flop synchronizer
  logic [CNT_W-1:0] cnt_q;
  logic [2:0]       bit_q;
  logic [7:0]       shift_q;
  logic             rx_s;
  logic             bit_end;

  assign rx_s    = sync_q[1];
  assign bit_end = cnt_q == CNT_W'(CLKS_PER_BIT - 1);
  assign rx_byte = shift_q; // valid with rx_valid

  always_ff @(posedge clk) begin
    if (rst) begin
      state_q  <= RX_IDLE;
      sync_q   <= 2'b11;
      cnt_q    <= '0;
      bit_q    <= '0;
      rx_valid <= 1'b0;
    end else begin
      sync_q   <= {sync_q[0], rx};
      rx_valid <= 1'b0;
      cnt_q    <= cnt_q + 1'b1;
      case (state_q)
        RX_IDLE: begin
          cnt_q <= '0;
          if (!rx_s) state_q <= RX_START;
        end
        RX_START: begin
          // recheck start bit at its middle, glitches go back to idle
          if (cnt_q == CNT_W'(CLKS_PER_BIT / 2 - 1)) begin
            cnt_q   <= '0;
            bit_q   <= '0;
            state_q <= rx_s ? RX_IDLE : RX_DATA;
          end
        end
        RX_DATA: begin
          if (bit_end) begin
            cnt_q   <= '0;
            shift_q <= {rx_s, shift_q[7:1]}; // lsb first
            bit_q   <= bit_q + 1'b1;
            if (bit_q == 3'd7) state_q <= RX_STOP;
          end
        end
        default: begin
          if (bit_end) begin
            rx_valid <= rx_s; // framing error drops the byte
            state_q  <= RX_IDLE;
          end
        end
      endcase
    end
  end

endmodule

//--- dac_sweep_pkg.sv
package dac_sweep_pkg;

  // sequencer states, one per kind of frame
  typedef enum logic [1:0] {
    ST_IDLE,
    ST_SOFT_RESET,
    ST_LDAC_SETUP,
    ST_SET_CHANNEL
  } seq_state_e;

  // which word the ROM builds
  typedef enum logic [2:0] {
    SEL_RESET,
    SEL_LDAC,
    SEL_CH_A,
    SEL_CH_B,
    SEL_CH_C,
    SEL_CH_D
  } word_sel_e;

  typedef struct packed {
    logic [3:0]  cmd;
    logic [3:0]  addr;
    logic [15:0] data;
  } dac_word_t;

  typedef struct packed {
    logic [7:0] a;
    logic [7:0] b;
    logic [7:0] c;
    logic [7:0] d;
  } sweep_levels_t;

  localparam logic [3:0] CMD_RESET        = 4'h5;
  localparam logic [3:0] CMD_LDAC         = 4'h6;
  localparam logic [3:0] CMD_WRITE_UPDATE = 4'h3;

  localparam logic [3:0] ADDR_CH_A = 4'h0;
  localparam logic [3:0] ADDR_CH_B = 4'h1;
  localparam logic [3:0] ADDR_CH_C = 4'h2;
  localparam logic [3:0] ADDR_CH_D = 4'h3;

  localparam dac_word_t WORD_RESET = '{cmd: CMD_RESET, addr: 4'h0, data: 16'h0001};
  localparam dac_word_t WORD_LDAC  = '{cmd: CMD_LDAC, addr: 4'h0, data: 16'h000f}; // ldac pin ignored

  localparam logic [7:0] CHAR_START = 8'h68; // "h"
  localparam logic [7:0] CHAR_STOP  = 8'h73; // "s"

endpackage
